//--- vlog.f
+incdir+common
common/gf64_pkg.sv
gf64_power/gf64_power41.sv
rtl/symbol_buffer.sv
rtl/pass_counter.sv
rtl/sbox_ctrl.sv
rtl/power_sbox_unit.sv
verif/power_sbox_assert.sv
verif/tb_power_sbox_unit.sv

//--- Bender.yml
package:
  name: power_sbox_unit

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/gf64_pkg.sv
      - gf64_power/gf64_power41.sv
      - rtl/symbol_buffer.sv
      - rtl/pass_counter.sv
      - rtl/sbox_ctrl.sv
      - rtl/power_sbox_unit.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/power_sbox_assert.sv
      - verif/tb_power_sbox_unit.sv

//--- verif/tb_power_sbox_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "gf64_consts.svh"

module tb_power_sbox_unit;

  localparam int DONE_LIMIT = 8 * `GF64_DEPTH + 32;  // Longest run plus margin.

  logic                      clk;
  logic                      arst_n;
  logic                      wr_en;
  logic [`GF64_AW-1:0]       wr_addr;
  gf64_pkg::gf64_sym_t       wr_data;
  logic [`GF64_AW-1:0]       rd_addr;
  wire gf64_pkg::gf64_sym_t  rd_data;
  logic                      start;
  logic [`GF64_RW-1:0]       rounds;
  wire                       busy;
  wire                       done;

  integer              seed;
  int                  errors;
  int                  tests_failed;
  gf64_pkg::gf64_sym_t load_buf [`GF64_DEPTH];
  gf64_pkg::gf64_sym_t read_buf [`GF64_DEPTH];
  gf64_pkg::gf64_sym_t keep_buf [`GF64_DEPTH];
  gf64_pkg::gf64_sym_t inv_buf  [`GF64_DEPTH];

  power_sbox_unit uut (
    .clk     (clk),
    .arst_n  (arst_n),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .start   (start),
    .rounds  (rounds),
    .busy    (busy),
    .done    (done)
  );

  always #4 clk = ~clk;

  // ============================================================
  // Checks
  // ============================================================

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] observed);
    assert (observed === expected) else begin
      $display("** Error at %0d ns: %s expected 0x%0h, observed 0x%0h",
               $time, name, expected, observed);
      errors++;
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond) else begin
      $display("Check failed at %0d ns: %s", $time, what);
      errors++;
    end
  endtask

  task automatic compare_with(input gf64_pkg::gf64_sym_t expected [`GF64_DEPTH]);
    for (int i = 0; i < `GF64_DEPTH; i++) begin
      check_value($sformatf("rd_data[%0d]", i), expected[i], read_buf[i]);
    end
  endtask

  task automatic report(input int num, input string name, input int mark);
    $display("Test %0d %s: %s", num, name, (errors == mark) ? "ok" : "FAILED");
    if (errors != mark) begin
      tests_failed++;
    end
  endtask

  // ============================================================
  // Host side
  // ============================================================

  task automatic fill_random();
    logic [31:0]           r;
    gf64_pkg::gf64_tower_u u;
    for (int i = 0; i < `GF64_DEPTH; i++) begin
      r          = $random(seed);
      u.tower.c0 = r[1:0];
      u.tower.c1 = r[3:2];
      u.tower.c2 = r[5:4];
      load_buf[i] = u.poly;
    end
  endtask

  task automatic load_symbols(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      #1;
      wr_en   = 1'b1;
      wr_addr = i[`GF64_AW-1:0];
      wr_data = load_buf[i];
    end
    @(posedge clk);  // Commits the last write.
    #1 wr_en = 1'b0;
  endtask

  task automatic read_symbols();
    for (int i = 0; i < `GF64_DEPTH; i++) begin
      @(posedge clk);
      #1 rd_addr = i[`GF64_AW-1:0];
      @(posedge clk);
      @(negedge clk);
      read_buf[i] = rd_data;
    end
  endtask

  task automatic pulse_start(input int r);
    @(posedge clk);
    #1;
    start  = 1'b1;
    rounds = r[`GF64_RW-1:0];
    @(posedge clk);
    #1 start = 1'b0;
  endtask

  // Cycle 0 is the one with start high.
  task automatic wait_done(input int first, output int cycles, output bit was_busy);
    bit seen;
    cycles   = first;
    seen     = 1'b0;
    was_busy = 1'b0;
    while (!seen && cycles <= DONE_LIMIT) begin
      @(negedge clk);
      if (busy) was_busy = 1'b1;
      if (done) begin
        seen = 1'b1;
      end else begin
        @(posedge clk);
        cycles++;
      end
    end
    if (!seen) begin
      $display("Timeout: done did not arrive within %0d cycles of start", DONE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  endtask

  task automatic run_rounds(input int r);
    int cycles;
    bit was_busy;
    pulse_start(r);
    wait_done(1, cycles, was_busy);
    check_value("done cycle", r * `GF64_DEPTH + 1, cycles);
    check_true(was_busy == (r != 0), "busy level did not match the round count");
  endtask

  // ============================================================
  // Test sequence
  // ============================================================

  initial begin
    int                    mark;
    int                    cycles;
    bit                    was_busy;
    bit                    seen_val [`GF64_DEPTH];
    gf64_pkg::gf64_tower_u u;
    clk     = 1'b0;
    arst_n  = 1'b0;
    wr_en   = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    rd_addr = '0;
    start   = 1'b0;
    rounds  = '0;
    seed = 32'h9d4d_d988;
    errors = 0;
    tests_failed = 0;
    repeat (4) @(posedge clk);
    #1 arst_n = 1'b1;

    mark = errors;
    u.poly = '0;
    load_buf[0] = u.poly;
    u.tower.c0 = 2'b01;  // Unit element.
    load_buf[1] = u.poly;
    load_symbols(2);
    run_rounds(1);
    read_symbols();
    check_value("rd_data[0]", 0, read_buf[0]);
    check_value("rd_data[1]", 1, read_buf[1]);
    report(1, "fixed points", mark);

    mark = errors;
    for (int i = 0; i < `GF64_DEPTH; i++) load_buf[i] = i[5:0];
    load_symbols(`GF64_DEPTH);
    run_rounds(1);
    read_symbols();
    seen_val = '{default: 1'b0};
    for (int i = 0; i < `GF64_DEPTH; i++) begin
      check_true(!seen_val[read_buf[i]],
                 $sformatf("result 0x%0h repeats at address %0d", read_buf[i], i));
      seen_val[read_buf[i]] = 1'b1;
      // Only 0 and 1 solve x^41 = x, since gcd(40, 63) = 1.
      if (i > 1) begin
        check_true(read_buf[i] != i[5:0],
                   $sformatf("symbol 0x%0h was left unchanged by one round", i));
      end
    end
    report(2, "permutation", mark);

    mark = errors;
    fill_random();
    keep_buf = load_buf;
    load_symbols(`GF64_DEPTH);
    run_rounds(6);
    read_symbols();
    compare_with(keep_buf);
    report(3, "period six", mark);

    mark = errors;
    fill_random();
    load_symbols(`GF64_DEPTH);
    run_rounds(3);
    read_symbols();
    inv_buf = read_buf;
    run_rounds(3);
    read_symbols();
    compare_with(load_buf);
    load_symbols(`GF64_DEPTH);
    run_rounds(1);
    run_rounds(2);  // Rounds add up across starts.
    read_symbols();
    compare_with(inv_buf);
    report(4, "inverse involution", mark);

    mark = errors;
    load_buf = keep_buf;
    load_symbols(`GF64_DEPTH);
    pulse_start(6);
    for (int k = 0; k < 10; k++) begin
      @(posedge clk);
      #1;
      wr_en   = 1'b1;
      wr_addr = k[`GF64_AW-1:0];
      wr_data = ~keep_buf[k];
      start   = 1'b1;
      rounds  = 3'd1;
    end
    @(posedge clk);
    #1;
    wr_en = 1'b0;
    start = 1'b0;
    wait_done(12, cycles, was_busy);
    check_value("done cycle", 6 * `GF64_DEPTH + 1, cycles);
    check_true(was_busy, "busy stayed low during the six-round run");
    read_symbols();
    compare_with(keep_buf);
    run_rounds(0);
    read_symbols();
    compare_with(keep_buf);
    report(5, "zero rounds and guards", mark);

    errors = errors + uut.u_assert.fail_count;
    $display("Tests: 5, failed: %0d, errors: %0d", tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/power_sbox_assert.sv
`timescale 1ns/1ps
`default_nettype none

module power_sbox_assert (
  input wire clk,
  input wire arst_n,
  input wire start,
  input wire busy,
  input wire done
);

  int fail_count = 0;

  // ============================================================
  // Control timing
  // ============================================================

  a_idle_after_reset: assert property (
    @(posedge clk) $rose(arst_n) |-> (!busy && !done)
  ) else begin
    $error("busy or done high in the first cycle after reset release");
    fail_count++;
  end

  a_done_one_cycle: assert property (
    @(posedge clk) disable iff (!arst_n) done |=> !done
  ) else begin
    $error("done held for more than one cycle");
    fail_count++;
  end

  // done comes as busy falls, or one cycle after a zero-round start.
  a_done_not_busy: assert property (
    @(posedge clk) disable iff (!arst_n)
      done |-> (!busy && ($past(busy) || $past(start)))
  ) else begin
    $error("done pulsed while busy was high or not as busy fell");
    fail_count++;
  end

  a_start_while_busy: assert property (
    @(posedge clk) disable iff (!arst_n) (start && busy) |=> (busy || done)
  ) else begin
    $error("start while busy changed busy");
    fail_count++;
  end

endmodule

bind power_sbox_unit power_sbox_assert u_assert (
  .clk    (clk),
  .arst_n (arst_n),
  .start  (start),
  .busy   (busy),
  .done   (done)
);

`default_nettype wire

//--- rtl/power_sbox_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "gf64_consts.svh"

module power_sbox_unit (
  input  wire                      clk,
  input  wire                      arst_n,
  input  wire                      wr_en,
  input  wire [`GF64_AW-1:0]       wr_addr,
  input  wire gf64_pkg::gf64_sym_t wr_data,
  input  wire [`GF64_AW-1:0]       rd_addr,
  output wire gf64_pkg::gf64_sym_t rd_data,
  input  wire                      start,
  input  wire [`GF64_RW-1:0]       rounds,
  output wire                      busy,
  output wire                      done
);

  wire                      clear;
  wire                      run;
  wire                      eng_we;
  wire                      host_we_ok;
  wire                      host_wr_en;
  wire                      rounds_zero;
  wire                      last_sym;
  wire                      last_round;
  wire [`GF64_AW-1:0]       eng_addr;
  wire gf64_pkg::gf64_sym_t eng_rdata;
  wire gf64_pkg::gf64_sym_t eng_wdata;

  assign host_wr_en  = wr_en && host_we_ok;  // Host writes blocked during a run.
  assign rounds_zero = (rounds == '0);

  // ============================================================
  // Control
  // ============================================================

  sbox_ctrl u_ctrl (
    .clk         (clk),
    .arst_n      (arst_n),
    .start       (start),
    .rounds_zero (rounds_zero),
    .last_sym    (last_sym),
    .last_round  (last_round),
    .clear       (clear),
    .run         (run),
    .eng_we      (eng_we),
    .host_we_ok  (host_we_ok),
    .busy        (busy),
    .done        (done)
  );

  pass_counter u_counter (
    .clk        (clk),
    .arst_n     (arst_n),
    .clear      (clear),
    .run        (run),
    .rounds     (rounds),
    .addr       (eng_addr),
    .last_sym   (last_sym),
    .last_round (last_round)
  );

  // ============================================================
  // Storage and power map
  // ============================================================

  symbol_buffer u_buffer (
    .clk       (clk),
    .arst_n    (arst_n),
    .wr_en     (host_wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .eng_we    (eng_we),
    .eng_addr  (eng_addr),
    .eng_wdata (eng_wdata),
    .eng_rdata (eng_rdata)
  );

  gf64_power41 u_power (
    .a (eng_rdata),
    .b (eng_wdata)
  );

endmodule

`default_nettype wire

//--- rtl/sbox_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module sbox_ctrl (
  input  wire clk,
  input  wire arst_n,
  input  wire start,
  input  wire rounds_zero,
  input  wire last_sym,
  input  wire last_round,
  output wire clear,
  output wire run,
  output wire eng_we,
  output wire host_we_ok,
  output wire busy,
  output wire done
);

  localparam logic [1:0] S_IDLE   = 2'd0;
  localparam logic [1:0] S_RUN    = 2'd1;
  localparam logic [1:0] S_FINISH = 2'd2;

  logic [1:0] state;
  logic [1:0] state_nxt;
  logic       accept;

  assign accept = start && (state == S_IDLE);  // Starts while busy are dropped.

  // ============================================================
  // Next state
  // ============================================================

  always_comb begin
    state_nxt = state;
    case (state)
      S_IDLE: begin
        if (accept) begin
          state_nxt = rounds_zero ? S_FINISH : S_RUN;
        end
      end
      S_RUN: begin
        // Last symbol of the last round.
        if (last_sym && last_round) begin
          state_nxt = S_FINISH;
        end
      end
      S_FINISH: begin
        state_nxt = S_IDLE;
      end
      default: begin
        state_nxt = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= S_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Outputs decode straight from the state register.
  assign clear      = accept;
  assign run        = (state == S_RUN);
  assign eng_we     = (state == S_RUN);  // One write-back per symbol.
  assign host_we_ok = (state != S_RUN);
  assign busy       = (state == S_RUN);
  assign done       = (state == S_FINISH);

endmodule

`default_nettype wire

//--- rtl/pass_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "gf64_consts.svh"

module pass_counter (
  input  wire                 clk,
  input  wire                 arst_n,
  input  wire                 clear,
  input  wire                 run,
  input  wire [`GF64_RW-1:0]  rounds,
  output logic [`GF64_AW-1:0] addr,
  output wire                 last_sym,
  output wire                 last_round
);

  logic [`GF64_RW-1:0] round_cnt;
  logic [`GF64_RW-1:0] round_last;

  // ============================================================
  // Address and round counters
  // ============================================================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      addr       <= '0;
      round_cnt  <= '0;
      round_last <= '0;
    end else if (clear) begin
      addr       <= '0;
      round_cnt  <= '0;
      round_last <= rounds - `GF64_RW'(1);  // Index of the final round.
    end else if (run) begin
      addr <= addr + `GF64_AW'(1);  // Wraps to 0 after the last symbol.
      if (last_sym) begin
        round_cnt <= round_cnt + `GF64_RW'(1);
      end
    end
  end

  assign last_sym   = (addr == `GF64_AW'(`GF64_DEPTH - 1));
  assign last_round = (round_cnt == round_last);

endmodule

`default_nettype wire

//--- rtl/symbol_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "gf64_consts.svh"

module symbol_buffer (
  input  wire                      clk,
  input  wire                      arst_n,
  input  wire                      wr_en,
  input  wire [`GF64_AW-1:0]       wr_addr,
  input  wire gf64_pkg::gf64_sym_t wr_data,
  input  wire [`GF64_AW-1:0]       rd_addr,
  output gf64_pkg::gf64_sym_t      rd_data,
  input  wire                      eng_we,
  input  wire [`GF64_AW-1:0]       eng_addr,
  input  wire gf64_pkg::gf64_sym_t eng_wdata,
  output wire gf64_pkg::gf64_sym_t eng_rdata
);

  gf64_pkg::gf64_sym_t mem [`GF64_DEPTH];

  // Single write port. The engine wins.
  always_ff @(posedge clk) begin
    if (eng_we) begin
      mem[eng_addr] <= eng_wdata;
    end else if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Host read, one cycle latency.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_data <= '0;
    end else begin
      rd_data <= mem[rd_addr];
    end
  end

  assign eng_rdata = mem[eng_addr];  // Same-cycle read for the map.

endmodule

`default_nettype wire

//--- gf64_power/gf64_power41.sv
`timescale 1ns/1ps
`default_nettype none

module gf64_power41 (
  input  wire gf64_pkg::gf64_sym_t a,
  output wire gf64_pkg::gf64_sym_t b
);

  // ============================================================
  // GF(4) helpers over w^2 + w + 1.
  // ============================================================

  function automatic gf64_pkg::gf4_t gf4_sq(input gf64_pkg::gf4_t x);
    gf4_sq = {x[1], x[1] ^ x[0]};  // Frobenius swaps w and w^2.
  endfunction

  function automatic gf64_pkg::gf4_t gf4_mul(input gf64_pkg::gf4_t x,
                                              input gf64_pkg::gf4_t y);
    logic t;
    t = x[1] & y[1];  // w*w folds back to w + 1.
    gf4_mul = {(x[0] & y[1]) ^ (x[1] & y[0]) ^ t, (x[0] & y[0]) ^ t};
  endfunction

  // Product with the constant w.
  function automatic gf64_pkg::gf4_t gf4_mul_w(input gf64_pkg::gf4_t x);
    gf4_mul_w = {x[1] ^ x[0], x[1]};
  endfunction

  // ============================================================
  // GF((2^2)^3) helpers over y^3 + w.
  // ============================================================

  // Squaring is linear. y^4 reduces to w*y.
  function automatic gf64_pkg::gf64_tower_u tower_sq(input gf64_pkg::gf64_tower_u x);
    gf64_pkg::gf64_tower_u r;
    r.tower.c0 = gf4_sq(x.tower.c0);
    r.tower.c1 = gf4_mul_w(gf4_sq(x.tower.c2));
    r.tower.c2 = gf4_sq(x.tower.c1);
    tower_sq   = r;
  endfunction

  function automatic gf64_pkg::gf64_tower_u tower_mul(input gf64_pkg::gf64_tower_u x,
                                                       input gf64_pkg::gf64_tower_u y);
    gf64_pkg::gf4_t p00;
    gf64_pkg::gf4_t p01;
    gf64_pkg::gf4_t p02;
    gf64_pkg::gf4_t p10;
    gf64_pkg::gf4_t p11;
    gf64_pkg::gf4_t p12;
    gf64_pkg::gf4_t p20;
    gf64_pkg::gf4_t p21;
    gf64_pkg::gf4_t p22;
    gf64_pkg::gf64_tower_u r;
    p00 = gf4_mul(x.tower.c0, y.tower.c0);
    p01 = gf4_mul(x.tower.c0, y.tower.c1);
    p02 = gf4_mul(x.tower.c0, y.tower.c2);
    p10 = gf4_mul(x.tower.c1, y.tower.c0);
    p11 = gf4_mul(x.tower.c1, y.tower.c1);
    p12 = gf4_mul(x.tower.c1, y.tower.c2);
    p20 = gf4_mul(x.tower.c2, y.tower.c0);
    p21 = gf4_mul(x.tower.c2, y.tower.c1);
    p22 = gf4_mul(x.tower.c2, y.tower.c2);
    // Terms of y^3 and y^4 come back scaled by w.
    r.tower.c0 = p00 ^ gf4_mul_w(p12 ^ p21);
    r.tower.c1 = p01 ^ p10 ^ gf4_mul_w(p22);
    r.tower.c2 = p02 ^ p11 ^ p20;
    tower_mul  = r;
  endfunction

  // ============================================================
  // Datapath
  // ============================================================

  gf64_pkg::gf64_tower_u t_in;
  gf64_pkg::gf64_tower_u t_x8;
  gf64_pkg::gf64_tower_u t_x32;
  gf64_pkg::gf64_tower_u t_out;

  // The polynomial basis is taken modulo z^6 + z^3 + 1 with z sent to y.
  // Then z^3 = w and every power z^i lands on a single tower bit.
  always_comb begin
    t_in.poly = {a[5], a[2], a[4], a[1], a[3], a[0]};
    t_x8      = tower_sq(tower_sq(tower_sq(t_in)));
    t_x32     = tower_sq(tower_sq(t_x8));
    t_out     = tower_mul(tower_mul(t_in, t_x8), t_x32);  // 41 = 1 + 8 + 32.
  end

  // Inverse basis change.
  assign b = {t_out.poly[5], t_out.poly[3], t_out.poly[1],
              t_out.poly[4], t_out.poly[2], t_out.poly[0]};

endmodule

`default_nettype wire

//--- common/gf64_pkg.sv
`default_nettype none

package gf64_pkg;

  // One GF(2^6) symbol in the polynomial basis.
  typedef logic [5:0] gf64_sym_t;

  // One GF(4) coefficient. Bit 0 holds the unit part, bit 1 the w part.
  typedef logic [1:0] gf4_t;

  // The same six bits seen flat or as a cubic over GF(4).
  typedef union packed {
    gf64_sym_t poly;
    struct packed {
      gf4_t c2;  // Coefficient of y^2.
      gf4_t c1;  // Coefficient of y.
      gf4_t c0;  // Constant term.
    } tower;
  } gf64_tower_u;

endpackage

`default_nettype wire

//--- common/gf64_consts.svh
`ifndef GF64_CONSTS_SVH
`define GF64_CONSTS_SVH

// ============================================================
// Buffer geometry
// ============================================================

// Number of symbols held by the buffer.
`define GF64_DEPTH 64

// Address width for GF64_DEPTH entries.
`define GF64_AW 6

// ============================================================
// Round count
// ============================================================

// Rounds 0 to 7.
`define GF64_RW 3

`endif
